// ==== lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// store queue slot count is a power of two so the pointers wrap
`define LSU_SQ_DEPTH 8

// recent loads remembered for ordering checks
`define LSU_LB_DEPTH 8

// data memory size in 32-bit words
`define LSU_MEM_WORDS 256

`endif

// ==== coreTypesPkg.sv ====
package coreTypesPkg;

    // circular program-order number
    typedef logic [5:0] SqN;
    typedef logic [5:0] RegTag;
    typedef logic [4:0] RegNm;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } LsuOp;

    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        LsuOp        opcode;
        RegTag       tagDst;
        RegNm        nmDst;
        SqN          sqN;
        SqN          loadSqN;
        SqN          storeSqN;
    } ExUop;

    typedef struct packed {
        logic [31:0] result;
        RegTag       tagDst;
        RegNm        nmDst;
        SqN          sqN;
        logic [31:0] pc;
        logic        valid;
    } ResUop;

    typedef struct packed {
        logic        taken;
        logic [31:0] dstPc;
        SqN          sqN;
        SqN          loadSqN;
        SqN          storeSqN;
    } BranchProv;

    // a is older than b when a - b is negative as a signed value
    function automatic logic isOlder(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) < 0;
    endfunction

    // flush keeps everything that is not younger than the flush point
    function automatic logic survives(SqN sqN, logic invalidate, SqN invalidateSqN);
        return !invalidate || !isOlder(invalidateSqN, sqN);
    endfunction

endpackage

// ==== memTypesPkg.sv ====
package memTypesPkg;

    typedef logic [29:0] WordAddr;
    typedef logic [3:0]  ByteMask;

    // pipeline request towards the store queue
    typedef struct packed {
        logic             valid;
        logic             isLoad;
        WordAddr          addr;
        logic [31:0]      data;
        ByteMask          wmask;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::SqN storeSqN;
    } MemReq;

    typedef struct packed {
        logic             valid;
        logic             isLoad;
        WordAddr          addr;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::SqN loadSqN;
    } LbReq;

    // data is already lane-shifted, wmask marks the live bytes
    typedef struct packed {
        logic             valid;
        WordAddr          addr;
        logic [31:0]      data;
        ByteMask          wmask;
        coreTypesPkg::SqN sqN;
    } SqEntry;

    typedef struct packed {
        logic             valid;
        WordAddr          addr;
        coreTypesPkg::SqN sqN;
    } LbEntry;

endpackage

// ==== dataMemory.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module dataMemory (
    input  logic                 clk,
    input  memTypesPkg::WordAddr rdAddr,
    output logic [31:0]          rdData,
    input  logic                 wrEn,
    input  memTypesPkg::WordAddr wrAddr,
    input  logic [31:0]          wrData,
    input  memTypesPkg::ByteMask wrMask
);
    localparam int IdxW = $clog2(`LSU_MEM_WORDS);

    logic [31:0] mem [`LSU_MEM_WORDS];

    // read-before-write on a shared address
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr[IdxW-1:0]];
        if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (wrMask[b]) begin
                    mem[wrAddr[IdxW-1:0]][8*b +: 8] <= wrData[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== storeQueue.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module storeQueue (
    input  logic                 clk,
    input  logic                 rst,
    input  memTypesPkg::MemReq   sqReq,
    input  logic                 invalidate,
    input  coreTypesPkg::SqN     invalidateSqN,
    input  logic [31:0]          memRdData,
    output memTypesPkg::WordAddr memRdAddr,
    output logic                 memWrEn,
    output memTypesPkg::WordAddr memWrAddr,
    output logic [31:0]          memWrData,
    output memTypesPkg::ByteMask memWrMask,
    output logic [31:0]          readData
);
    localparam int IdxW = $clog2(`LSU_SQ_DEPTH);
    localparam int CntW = IdxW + 1;

    memTypesPkg::SqEntry       entries [`LSU_SQ_DEPTH];
    memTypesPkg::SqEntry       headEntry;
    memTypesPkg::SqEntry       drained;
    logic [`LSU_SQ_DEPTH-1:0]  live;
    logic [IdxW-1:0]           head;
    logic [IdxW-1:0]           headNext;
    logic [IdxW-1:0]           pushIdx;
    logic [CntW-1:0]           count;
    logic [CntW-1:0]           kept;
    logic [CntW-1:0]           keptAfterPop;
    logic                      pop;
    logic                      push;
    memTypesPkg::WordAddr      ldAddr;
    coreTypesPkg::SqN          ldSqN;
    logic [31:0]               merged;

    function automatic logic hits(memTypesPkg::SqEntry st, memTypesPkg::WordAddr a,
                                  coreTypesPkg::SqN loadSqN);
        return st.valid && st.addr == a && coreTypesPkg::isOlder(st.sqN, loadSqN);
    endfunction

    function automatic logic [31:0] applyStore(logic [31:0] base, memTypesPkg::SqEntry st);
        logic [31:0] res;
        res = base;
        for (int b = 0; b < 4; b++) begin
            if (st.wmask[b]) begin
                res[8*b +: 8] = st.data[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            live[i] = entries[i].valid
                && coreTypesPkg::survives(entries[i].sqN, invalidate, invalidateSqN);
        end
    end

    assign headEntry = entries[head];
    assign pop = live[head];
    assign kept = CntW'($countones(live));
    assign keptAfterPop = kept - CntW'(pop);
    assign headNext = head + IdxW'(pop);
    // survivors sit right behind the head, so a flush rolls the tail back
    assign pushIdx = headNext + keptAfterPop[IdxW-1:0];
    assign push = sqReq.valid && !sqReq.isLoad
        && coreTypesPkg::survives(sqReq.sqN, invalidate, invalidateSqN);

    assign memRdAddr = sqReq.addr;
    assign memWrEn = pop;
    assign memWrAddr = headEntry.addr;
    assign memWrData = headEntry.data;
    assign memWrMask = headEntry.wmask;

    // memory returns the word from before the last drain, so replay that drain first
    always_comb begin
        logic [IdxW-1:0] idx;
        merged = memRdData;
        if (hits(drained, ldAddr, ldSqN)) begin
            merged = applyStore(merged, drained);
        end
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
            idx = head + IdxW'(k);
            if (hits(entries[idx], ldAddr, ldSqN)) begin
                merged = applyStore(merged, entries[idx]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            if (!live[i]) begin
                entries[i].valid <= 1'b0;
            end
        end
        if (pop) begin
            entries[head].valid <= 1'b0;
        end
        if (push) begin
            entries[pushIdx] <= '{valid: 1'b1, addr: sqReq.addr, data: sqReq.data,
                                  wmask: sqReq.wmask, sqN: sqReq.sqN};
        end
        head <= headNext;
        count <= keptAfterPop + CntW'(push);
        drained <= headEntry;
        drained.valid <= pop;
        if (sqReq.valid && sqReq.isLoad) begin
            ldAddr <= sqReq.addr;
            ldSqN <= sqReq.sqN;
        end
        readData <= merged;
        if (rst) begin
            for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            head <= '0;
            count <= '0;
            drained.valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) push |-> keptAfterPop < CntW'(`LSU_SQ_DEPTH))
        else $error("store queue overflow");

    // count and valid bits must agree after every flush rollback
    assert property (@(posedge clk) disable iff (rst) (count != '0) |-> entries[head].valid)
        else $error("store queue head invalid while not empty");

endmodule

// ==== loadBuffer.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module loadBuffer (
    input  logic              clk,
    input  logic              rst,
    input  memTypesPkg::LbReq lbReq,
    input  logic              invalidate,
    input  coreTypesPkg::SqN  invalidateSqN,
    output logic              mispred
);
    localparam int IdxW = $clog2(`LSU_LB_DEPTH);

    memTypesPkg::LbEntry window [`LSU_LB_DEPTH];
    logic [IdxW-1:0]     wrPtr;
    logic                reqLive;
    logic                conflict;

    assign reqLive = lbReq.valid
        && coreTypesPkg::survives(lbReq.sqN, invalidate, invalidateSqN);

    // a store hitting a younger load that already read its word
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
            if (window[i].valid && window[i].addr == lbReq.addr
                    && coreTypesPkg::isOlder(lbReq.sqN, window[i].sqN)) begin
                conflict = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
            if (!coreTypesPkg::survives(window[i].sqN, invalidate, invalidateSqN)) begin
                window[i].valid <= 1'b0;
            end
        end
        mispred <= reqLive && !lbReq.isLoad && conflict;
        // oldest slot gets overwritten
        if (reqLive && lbReq.isLoad) begin
            window[wrPtr] <= '{valid: 1'b1, addr: lbReq.addr, sqN: lbReq.sqN};
            wrPtr <= wrPtr + 1'b1;
        end
        if (rst) begin
            for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
                window[i].valid <= 1'b0;
            end
            wrPtr <= '0;
            mispred <= 1'b0;
        end
    end

endmodule

// ==== loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  coreTypesPkg::ExUop      inUop,
    input  logic                    invalidate,
    input  coreTypesPkg::SqN        invalidateSqN,
    input  logic [31:0]             readData,
    input  logic                    mispred,
    output memTypesPkg::MemReq      sqReq,
    output memTypesPkg::LbReq       lbReq,
    output coreTypesPkg::BranchProv branchProv,
    output logic                    wbReq,
    output coreTypesPkg::ResUop     resUop
);
    // op state carried down i0, i1, i2
    typedef struct packed {
        logic                valid;
        coreTypesPkg::LsuOp  opcode;
        coreTypesPkg::RegTag tagDst;
        coreTypesPkg::RegNm  nmDst;
        coreTypesPkg::SqN    sqN;
        coreTypesPkg::SqN    loadSqN;
        coreTypesPkg::SqN    storeSqN;
        logic [1:0]          byteIdx;
        logic [31:0]         pc;
    } StageOp;

    StageOp                  i0;
    StageOp                  i1;
    StageOp                  i2;
    StageOp                  i0Next;
    StageOp                  i1Next;
    StageOp                  i2Next;
    memTypesPkg::MemReq      sqReqNext;
    memTypesPkg::LbReq       lbReqNext;
    coreTypesPkg::BranchProv branchNext;
    coreTypesPkg::ResUop     resNext;
    logic [31:0]             addr;
    logic                    inLive;
    logic                    isStore;
    memTypesPkg::ByteMask    stMask;
    logic [31:0]             stData;
    logic [7:0]              ldByte;
    logic [15:0]             ldHalf;
    logic [31:0]             ldResult;

    assign addr = inUop.srcA + inUop.imm;
    assign inLive = inValid && coreTypesPkg::survives(inUop.sqN, invalidate, invalidateSqN);
    assign isStore = inUop.opcode inside {coreTypesPkg::SB, coreTypesPkg::SH, coreTypesPkg::SW};
    assign wbReq = i2.valid;

    // store data moves into the lanes picked by the low address bits
    always_comb begin
        stMask = 4'b0000;
        stData = inUop.srcB;
        case (inUop.opcode)
            coreTypesPkg::SB: begin
                stMask = 4'b0001 << addr[1:0];
                stData = inUop.srcB << {addr[1:0], 3'b000};
            end
            coreTypesPkg::SH: begin
                stMask = addr[1] ? 4'b1100 : 4'b0011;
                stData = inUop.srcB << {addr[1], 4'b0000};
            end
            coreTypesPkg::SW: stMask = 4'b1111;
            default: stMask = 4'b0000;
        endcase
    end

    always_comb begin
        i0Next.valid = inLive;
        i0Next.opcode = inUop.opcode;
        i0Next.tagDst = inUop.tagDst;
        i0Next.nmDst = inUop.nmDst;
        i0Next.sqN = inUop.sqN;
        i0Next.loadSqN = inUop.loadSqN;
        i0Next.storeSqN = inUop.storeSqN;
        i0Next.byteIdx = addr[1:0];
        i0Next.pc = inUop.pc;

        sqReqNext.valid = inLive;
        sqReqNext.isLoad = !isStore;
        sqReqNext.addr = addr[31:2];
        sqReqNext.data = stData;
        sqReqNext.wmask = stMask;
        sqReqNext.sqN = inUop.sqN;
        sqReqNext.storeSqN = inUop.storeSqN;

        lbReqNext.valid = inLive;
        lbReqNext.isLoad = !isStore;
        lbReqNext.addr = addr[31:2];
        lbReqNext.sqN = inUop.sqN;
        lbReqNext.loadSqN = inUop.loadSqN;

        i1Next = i0;
        i1Next.valid = i0.valid && coreTypesPkg::survives(i0.sqN, invalidate, invalidateSqN);
        i2Next = i1;
        i2Next.valid = i1.valid && coreTypesPkg::survives(i1.sqN, invalidate, invalidateSqN);

        // ordering violation restarts fetch after the op in i1
        branchNext.taken = i2Next.valid && mispred;
        branchNext.dstPc = i1.pc + 32'd4;
        branchNext.sqN = i1.sqN;
        branchNext.loadSqN = i1.loadSqN;
        branchNext.storeSqN = i1.storeSqN;
    end

    // load extraction from the merged word
    always_comb begin
        ldByte = readData[{i2.byteIdx, 3'b000} +: 8];
        ldHalf = i2.byteIdx[1] ? readData[31:16] : readData[15:0];
        case (i2.opcode)
            coreTypesPkg::LB:  ldResult = {{24{ldByte[7]}}, ldByte};
            coreTypesPkg::LBU: ldResult = {24'b0, ldByte};
            coreTypesPkg::LH:  ldResult = {{16{ldHalf[15]}}, ldHalf};
            coreTypesPkg::LHU: ldResult = {16'b0, ldHalf};
            coreTypesPkg::LW:  ldResult = readData;
            default:           ldResult = 32'b0;
        endcase

        resNext.result = ldResult;
        resNext.tagDst = i2.tagDst;
        resNext.nmDst = i2.nmDst;
        resNext.sqN = i2.sqN;
        resNext.pc = i2.pc;
        resNext.valid = i2.valid && coreTypesPkg::survives(i2.sqN, invalidate, invalidateSqN);
    end

    always_ff @(posedge clk) begin
        i0 <= i0Next;
        i1 <= i1Next;
        i2 <= i2Next;
        sqReq <= sqReqNext;
        lbReq <= lbReqNext;
        branchProv <= branchNext;
        resUop <= resNext;
        if (rst) begin
            i0.valid <= 1'b0;
            i1.valid <= 1'b0;
            i2.valid <= 1'b0;
            sqReq.valid <= 1'b0;
            lbReq.valid <= 1'b0;
            branchProv.taken <= 1'b0;
            resUop.valid <= 1'b0;
        end
    end

    // the whole pipe is empty once reset has been seen
    assert property (@(posedge clk) rst |=> !wbReq)
        else $error("wbReq high in the cycle after reset");

endmodule

// ==== memSubsystem.sv ====
`timescale 1ns/10ps

module memSubsystem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  coreTypesPkg::ExUop      inUop,
    input  logic                    invalidate,
    input  coreTypesPkg::SqN        invalidateSqN,
    output logic                    wbReq,
    output coreTypesPkg::ResUop     resUop,
    output coreTypesPkg::BranchProv branchProv
);
    memTypesPkg::MemReq   sqReq;
    memTypesPkg::LbReq    lbReq;
    memTypesPkg::WordAddr memRdAddr;
    logic [31:0]          memRdData;
    logic                 memWrEn;
    memTypesPkg::WordAddr memWrAddr;
    logic [31:0]          memWrData;
    memTypesPkg::ByteMask memWrMask;
    logic [31:0]          readData;
    logic                 mispred;

    loadStoreUnit lsu_i (
        .clk, .rst, .inValid, .inUop, .invalidate, .invalidateSqN,
        .readData, .mispred, .sqReq, .lbReq, .branchProv, .wbReq, .resUop
    );

    storeQueue sq_i (
        .clk, .rst, .sqReq, .invalidate, .invalidateSqN, .memRdData,
        .memRdAddr, .memWrEn, .memWrAddr, .memWrData, .memWrMask, .readData
    );

    loadBuffer lb_i (
        .clk, .rst, .lbReq, .invalidate, .invalidateSqN, .mispred
    );

    dataMemory mem_i (
        .clk,
        .rdAddr(memRdAddr),
        .rdData(memRdData),
        .wrEn(memWrEn),
        .wrAddr(memWrAddr),
        .wrData(memWrData),
        .wrMask(memWrMask)
    );

endmodule

// ==== lsuTb.sv ====
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsuTb;
    localparam int MemIdxW = $clog2(`LSU_MEM_WORDS);

    // value holds the load result or the redirect target
    typedef struct packed {
        coreTypesPkg::SqN    sqN;
        logic [31:0]         value;
        logic [31:0]         pc;
        coreTypesPkg::RegTag tagDst;
        coreTypesPkg::RegNm  nmDst;
        logic [31:0]         cycle;
    } Expect;

    logic                    clk;
    logic                    rst;
    logic                    inValid;
    coreTypesPkg::ExUop      inUop;
    logic                    invalidate;
    coreTypesPkg::SqN        invalidateSqN;
    logic                    wbReq;
    coreTypesPkg::ResUop     resUop;
    coreTypesPkg::BranchProv branchProv;

    logic [31:0]      cycle;
    int               errors;
    int               testsPassed;
    int               testsFailed;
    coreTypesPkg::SqN nextSqN;
    logic             wbPrev;
    Expect            resQ[$];
    Expect            brQ[$];

    // memory image and the window of recent loads
    logic [31:0]      refMem [`LSU_MEM_WORDS];
    logic [29:0]      winAddr [`LSU_LB_DEPTH];
    coreTypesPkg::SqN winSqN [`LSU_LB_DEPTH];
    logic             winValid [`LSU_LB_DEPTH];
    int               winPtr;

    memSubsystem dut_i (
        .clk, .rst, .inValid, .inUop, .invalidate, .invalidateSqN,
        .wbReq, .resUop, .branchProv
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // a comes first when a - b is negative in 6-bit two's complement
    function automatic logic olderThan(coreTypesPkg::SqN a, coreTypesPkg::SqN b);
        logic signed [5:0] diff;
        diff = a - b;
        return diff < 0;
    endfunction

    function automatic logic [31:0] pcOf(coreTypesPkg::SqN sqN);
        return 32'h1000 + {24'h0, sqN, 2'b00};
    endfunction

    function automatic coreTypesPkg::SqN takeSqN();
        coreTypesPkg::SqN s;
        s = nextSqN;
        nextSqN = nextSqN + 6'd1;
        return s;
    endfunction

    // ops arrive here in program order, except where a test reorders them on purpose
    function automatic void refExecute(input coreTypesPkg::LsuOp op, input logic [31:0] addr,
            input logic [31:0] data, input coreTypesPkg::SqN sqN,
            output logic [31:0] result, output logic redirect);
        logic [MemIdxW-1:0] idx;
        logic [31:0]        word;
        logic [7:0]         lane8;
        logic [15:0]        lane16;
        idx = addr[2 +: MemIdxW];
        word = refMem[idx];
        lane8 = word[8*addr[1:0] +: 8];
        lane16 = word[16*addr[1] +: 16];
        result = 32'h0;
        redirect = 1'b0;
        case (op)
            coreTypesPkg::LB:  result = {{24{lane8[7]}}, lane8};
            coreTypesPkg::LBU: result = {24'h0, lane8};
            coreTypesPkg::LH:  result = {{16{lane16[15]}}, lane16};
            coreTypesPkg::LHU: result = {16'h0, lane16};
            coreTypesPkg::LW:  result = word;
            coreTypesPkg::SB:  word[8*addr[1:0] +: 8] = data[7:0];
            coreTypesPkg::SH:  word[16*addr[1] +: 16] = data[15:0];
            default:           word = data;
        endcase
        if (op inside {coreTypesPkg::SB, coreTypesPkg::SH, coreTypesPkg::SW}) begin
            refMem[idx] = word;
            // a younger load already read this word
            for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
                if (winValid[i] && winAddr[i] == addr[31:2] && olderThan(sqN, winSqN[i])) begin
                    redirect = 1'b1;
                end
            end
        end else begin
            winValid[winPtr] = 1'b1;
            winAddr[winPtr] = addr[31:2];
            winSqN[winPtr] = sqN;
            winPtr = (winPtr + 1) % `LSU_LB_DEPTH;
        end
    endfunction

    task automatic nextStep();
        @(posedge clk);
        #2;
        inValid = 1'b0;
        invalidate = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            nextStep();
        end
    endtask

    task automatic issueOp(input coreTypesPkg::LsuOp op, input logic [31:0] addr,
            input logic [31:0] data, input coreTypesPkg::SqN sqN, input logic killed);
        logic [31:0] result;
        logic        redirect;
        logic [31:0] imm;
        Expect       e;
        nextStep();
        imm = $urandom_range(0, 255);
        inValid = 1'b1;
        inUop.srcA = addr - imm;
        inUop.srcB = data;
        inUop.imm = imm;
        inUop.pc = pcOf(sqN);
        inUop.opcode = op;
        inUop.tagDst = 6'($urandom);
        inUop.nmDst = 5'($urandom);
        inUop.sqN = sqN;
        inUop.loadSqN = sqN;
        inUop.storeSqN = sqN;
        if (!killed) begin
            refExecute(op, addr, data, sqN, result, redirect);
            e = '{sqN: sqN, value: result, pc: pcOf(sqN), tagDst: inUop.tagDst,
                  nmDst: inUop.nmDst, cycle: cycle + 32'd4};
            resQ.push_back(e);
            if (redirect) begin
                e.value = pcOf(sqN) + 32'd4;
                e.cycle = cycle + 32'd3;
                brQ.push_back(e);
            end
        end
    endtask

    task automatic flushYounger(input coreTypesPkg::SqN f);
        nextStep();
        invalidate = 1'b1;
        invalidateSqN = f;
        for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
            if (olderThan(f, winSqN[i])) begin
                winValid[i] = 1'b0;
            end
        end
        nextSqN = f + 6'd1;
    endtask

    task automatic finishTest(input int num, input string name, input int errBefore);
        int n;
        n = 0;
        nextStep();
        while ((resQ.size() != 0 || brQ.size() != 0) && n < 20) begin
            nextStep();
            n++;
        end
        if (resQ.size() != 0 || brQ.size() != 0) begin
            testsFailed++;
            $display("test %0d %s: timed out with %0d results and %0d redirects outstanding",
                     num, name, resQ.size(), brQ.size());
            resQ.delete();
            brQ.delete();
        end else if (errors == errBefore) begin
            testsPassed++;
            $display("test %0d %s: passed", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - errBefore);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        Expect e;
        if (!rst) begin
            if (resQ.size() != 0 && resQ[0].cycle == cycle) begin
                e = resQ.pop_front();
                if (resUop.valid !== 1'b1) begin
                    errors++;
                    $display("no result for sqN %h at cycle %0d", e.sqN, cycle);
                end else begin
                    if (resUop.sqN !== e.sqN) begin
                        errors++;
                        $display("FAILED resUop.sqN got %h expected %h", resUop.sqN, e.sqN);
                    end
                    if (resUop.result !== e.value) begin
                        errors++;
                        $display("FAILED resUop.result got %h expected %h (sqN %h)",
                                 resUop.result, e.value, e.sqN);
                    end
                    if (resUop.pc !== e.pc) begin
                        errors++;
                        $display("FAILED resUop.pc got %h expected %h", resUop.pc, e.pc);
                    end
                    if (resUop.tagDst !== e.tagDst || resUop.nmDst !== e.nmDst) begin
                        errors++;
                        $display("FAILED resUop.tagDst/nmDst got %h/%h expected %h/%h",
                                 resUop.tagDst, resUop.nmDst, e.tagDst, e.nmDst);
                    end
                    if (wbPrev !== 1'b1) begin
                        errors++;
                        $display("wbReq was not high in the cycle before result sqN %h", e.sqN);
                    end
                end
            end else if (resUop.valid === 1'b1) begin
                errors++;
                $display("unexpected result for sqN %h at cycle %0d", resUop.sqN, cycle);
            end
            if (brQ.size() != 0 && brQ[0].cycle == cycle) begin
                e = brQ.pop_front();
                if (branchProv.taken !== 1'b1) begin
                    errors++;
                    $display("missing redirect for store sqN %h at cycle %0d", e.sqN, cycle);
                end else begin
                    if (branchProv.dstPc !== e.value) begin
                        errors++;
                        $display("FAILED branchProv.dstPc got %h expected %h",
                                 branchProv.dstPc, e.value);
                    end
                    if (branchProv.sqN !== e.sqN) begin
                        errors++;
                        $display("FAILED branchProv.sqN got %h expected %h",
                                 branchProv.sqN, e.sqN);
                    end
                    if (branchProv.loadSqN !== e.sqN || branchProv.storeSqN !== e.sqN) begin
                        errors++;
                        $display("FAILED branchProv.loadSqN/storeSqN got %h/%h expected %h/%h",
                                 branchProv.loadSqN, branchProv.storeSqN, e.sqN, e.sqN);
                    end
                end
            end else if (branchProv.taken === 1'b1) begin
                errors++;
                $display("unexpected redirect for sqN %h at cycle %0d", branchProv.sqN, cycle);
            end
        end
        wbPrev = wbReq;
    end

    initial begin : main
        int                 errBefore;
        coreTypesPkg::SqN   s;
        coreTypesPkg::LsuOp op;
        logic [31:0]        a;
        void'($urandom(32'h8e1e));
        rst = 1'b1;
        inValid = 1'b0;
        inUop = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        cycle = 32'd0;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        nextSqN = '0;
        wbPrev = 1'b0;
        winPtr = 0;
        for (int i = 0; i < `LSU_LB_DEPTH; i++) begin
            winValid[i] = 1'b0;
            winSqN[i] = '0;
            winAddr[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        errBefore = errors;
        issueOp(coreTypesPkg::SW, 32'h100, 32'hdeadbeef, takeSqN(), 1'b0);
        idle(3);
        issueOp(coreTypesPkg::LW, 32'h100, 32'h0, takeSqN(), 1'b0);
        finishTest(1, "store then load word", errBefore);

        errBefore = errors;
        issueOp(coreTypesPkg::SW, 32'h140, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SW, 32'h144, 32'h0, takeSqN(), 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            issueOp(coreTypesPkg::SB, 32'h140 + lane, 32'h3cc37f81 >> (8 * lane),
                    takeSqN(), 1'b0);
        end
        issueOp(coreTypesPkg::SH, 32'h144, 32'h12348001, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SH, 32'h146, 32'h56787ffe, takeSqN(), 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            issueOp(coreTypesPkg::LB, 32'h140 + lane, 32'h0, takeSqN(), 1'b0);
            issueOp(coreTypesPkg::LBU, 32'h140 + lane, 32'h0, takeSqN(), 1'b0);
        end
        for (int h = 0; h < 4; h += 2) begin
            issueOp(coreTypesPkg::LH, 32'h144 + h, 32'h0, takeSqN(), 1'b0);
            issueOp(coreTypesPkg::LHU, 32'h144 + h, 32'h0, takeSqN(), 1'b0);
            issueOp(coreTypesPkg::LH, 32'h140 + h, 32'h0, takeSqN(), 1'b0);
            issueOp(coreTypesPkg::LHU, 32'h140 + h, 32'h0, takeSqN(), 1'b0);
        end
        finishTest(2, "byte and half lanes with extension", errBefore);

        errBefore = errors;
        issueOp(coreTypesPkg::SW, 32'h180, 32'h11223344, takeSqN(), 1'b0);
        idle(4);
        issueOp(coreTypesPkg::SW, 32'h184, 32'hcafef00d, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::LW, 32'h184, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SB, 32'h182, 32'h000000ab, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::LW, 32'h180, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SH, 32'h186, 32'h0000beef, takeSqN(), 1'b0);
        idle(1);
        issueOp(coreTypesPkg::LHU, 32'h186, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::LW, 32'h184, 32'h0, takeSqN(), 1'b0);
        finishTest(3, "store to load forwarding", errBefore);

        errBefore = errors;
        issueOp(coreTypesPkg::SW, 32'h1c0, 32'h0a0a0a0a, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SW, 32'h1c4, 32'h0b0b0b0b, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::SW, 32'h1c8, 32'h0c0c0c0c, takeSqN(), 1'b0);
        idle(4);
        s = nextSqN;
        issueOp(coreTypesPkg::SW, 32'h1c0, 32'h11111111, s, 1'b0);
        issueOp(coreTypesPkg::SW, 32'h1c4, 32'h22222222, s + 6'd1, 1'b0);
        // these two are younger than the flush point
        issueOp(coreTypesPkg::SW, 32'h1c8, 32'h33333333, s + 6'd2, 1'b1);
        issueOp(coreTypesPkg::LW, 32'h1c0, 32'h0, s + 6'd3, 1'b1);
        flushYounger(s + 6'd1);
        idle(2);
        issueOp(coreTypesPkg::LW, 32'h1c0, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::LW, 32'h1c4, 32'h0, takeSqN(), 1'b0);
        issueOp(coreTypesPkg::LW, 32'h1c8, 32'h0, takeSqN(), 1'b0);
        finishTest(4, "flush of younger ops", errBefore);

        errBefore = errors;
        issueOp(coreTypesPkg::SW, 32'h200, 32'h55667788, takeSqN(), 1'b0);
        idle(4);
        s = nextSqN;
        nextSqN = s + 6'd2;
        // load overtakes the store that comes before it in program order
        issueOp(coreTypesPkg::LW, 32'h200, 32'h0, s + 6'd1, 1'b0);
        issueOp(coreTypesPkg::SW, 32'h200, 32'h99aabbcc, s, 1'b0);
        issueOp(coreTypesPkg::LW, 32'h200, 32'h0, takeSqN(), 1'b0);
        finishTest(5, "ordering violation redirect", errBefore);

        errBefore = errors;
        for (int w = 0; w < 16; w++) begin
            issueOp(coreTypesPkg::SW, 32'h40 + 4 * w, $urandom, takeSqN(), 1'b0);
        end
        for (int k = 0; k < 200; k++) begin
            op = coreTypesPkg::LsuOp'($urandom_range(0, 7));
            a = 32'h40 + ($urandom_range(0, 15) << 2) + $urandom_range(0, 3);
            if (op inside {coreTypesPkg::LH, coreTypesPkg::LHU, coreTypesPkg::SH}) begin
                a[0] = 1'b0;
            end else if (op inside {coreTypesPkg::LW, coreTypesPkg::SW}) begin
                a[1:0] = 2'b00;
            end
            issueOp(op, a, $urandom, takeSqN(), 1'b0);
            if ($urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, 2));
            end
        end
        finishTest(6, "random mix", errBefore);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, errors);
        if (testsFailed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
coreTypesPkg.sv
memTypesPkg.sv
dataMemory.sv
storeQueue.sv
loadBuffer.sv
loadStoreUnit.sv
memSubsystem.sv
lsuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
